/* verilog/rv_exec_pkg.sv */
`default_nettype none

package rv_exec_pkg;

    // ==============================
    // basic widths
    // ==============================
    typedef logic [31:0] word_t;     // operands, results, pc values
    typedef logic [4:0]  reg_addr_t; // x0..x31
    typedef logic [3:0]  alu_op_t;
    typedef logic [6:0]  opcode_t;   // instr[6:0]
    typedef logic [2:0]  br_funct_t; // funct3 of a branch

    localparam word_t INSTR_BYTES = 32'd4; // pc step

    // ==============================
    // alu operation codes
    // ==============================
    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_SUB  = 4'd1;
    localparam alu_op_t ALU_SLL  = 4'd2;
    localparam alu_op_t ALU_SLT  = 4'd3; // signed
    localparam alu_op_t ALU_SLTU = 4'd4; // unsigned
    localparam alu_op_t ALU_XOR  = 4'd5;
    localparam alu_op_t ALU_SRL  = 4'd6;
    localparam alu_op_t ALU_SRA  = 4'd7;
    localparam alu_op_t ALU_OR   = 4'd8;
    localparam alu_op_t ALU_AND  = 4'd9;

    // ==============================
    // major opcodes kept by the unit
    // ==============================
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;

    // branch conditions, 010 and 011 are unused
    localparam br_funct_t BR_BEQ  = 3'b000;
    localparam br_funct_t BR_BNE  = 3'b001;
    localparam br_funct_t BR_BLT  = 3'b100;
    localparam br_funct_t BR_BGE  = 3'b101;
    localparam br_funct_t BR_BLTU = 3'b110;
    localparam br_funct_t BR_BGEU = 3'b111;

endpackage

`default_nettype wire

/* verilog/alu.sv */
`timescale 1ns/10ps
`default_nettype none

module alu (
    input  wire rv_exec_pkg::alu_op_t alu_op_i,
    input  wire rv_exec_pkg::word_t   a_i,
    input  wire rv_exec_pkg::word_t   b_i,
    output rv_exec_pkg::word_t        result_o
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b_i[4:0]; // only the low 5 bits count
    assign lt_signed   = $signed(a_i) < $signed(b_i);
    assign lt_unsigned = a_i < b_i;

    always_comb begin
        case (alu_op_i)
            rv_exec_pkg::ALU_ADD:  result_o = a_i + b_i;
            rv_exec_pkg::ALU_SUB:  result_o = a_i - b_i;
            rv_exec_pkg::ALU_SLL:  result_o = a_i << shamt;
            rv_exec_pkg::ALU_SLT:  result_o = {31'b0, lt_signed};
            rv_exec_pkg::ALU_SLTU: result_o = {31'b0, lt_unsigned};
            rv_exec_pkg::ALU_XOR:  result_o = a_i ^ b_i;
            rv_exec_pkg::ALU_SRL:  result_o = a_i >> shamt;
            rv_exec_pkg::ALU_SRA:  result_o = $signed(a_i) >>> shamt; // sign fill
            rv_exec_pkg::ALU_OR:   result_o = a_i | b_i;
            rv_exec_pkg::ALU_AND:  result_o = a_i & b_i;
            default:               result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/branch_resolver.sv */
`timescale 1ns/10ps
`default_nettype none

module branch_resolver (
    input  wire                         is_branch_i,
    input  wire                         is_jump_i,
    input  wire                         is_jalr_i,
    input  wire rv_exec_pkg::br_funct_t br_funct_i,
    input  wire rv_exec_pkg::word_t     rs1_val_i,
    input  wire rv_exec_pkg::word_t     rs2_val_i,
    input  wire rv_exec_pkg::word_t     imm_i,
    input  wire rv_exec_pkg::word_t     pc_i,
    output logic                        taken_o,
    output rv_exec_pkg::word_t          target_o,
    output rv_exec_pkg::word_t          link_o
);

    logic               eq;
    logic               lt_s;
    logic               lt_u;
    logic               cond;
    rv_exec_pkg::word_t jalr_sum;

    assign eq   = (rs1_val_i == rs2_val_i);
    assign lt_s = $signed(rs1_val_i) < $signed(rs2_val_i);
    assign lt_u = rs1_val_i < rs2_val_i;

    always_comb begin
        case (br_funct_i)
            rv_exec_pkg::BR_BEQ:  cond = eq;
            rv_exec_pkg::BR_BNE:  cond = !eq;
            rv_exec_pkg::BR_BLT:  cond = lt_s;
            rv_exec_pkg::BR_BGE:  cond = !lt_s;
            rv_exec_pkg::BR_BLTU: cond = lt_u;
            rv_exec_pkg::BR_BGEU: cond = !lt_u;
            default:              cond = 1'b0; // reserved encodings never branch
        endcase
    end

    // jumps are unconditional
    assign taken_o = is_jump_i || (is_branch_i && cond);

    // jalr target drops bit 0
    assign jalr_sum = rs1_val_i + imm_i;
    assign target_o = is_jalr_i ? {jalr_sum[31:1], 1'b0} : pc_i + imm_i;

    assign link_o = pc_i + rv_exec_pkg::INSTR_BYTES;

endmodule

`default_nettype wire

/* verilog/instr_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module instr_decoder (
    input  wire                         clk,
    input  wire                         rst_n,
    // upstream handshake
    input  wire                         in_valid_i,
    output logic                        in_ready_o,
    input  wire rv_exec_pkg::word_t     instr_i,
    input  wire rv_exec_pkg::word_t     pc_i,
    input  wire rv_exec_pkg::word_t     rs1_val_i,
    input  wire rv_exec_pkg::word_t     rs2_val_i,
    // decoded bundle towards execute
    input  wire                         dec_ready_i,
    output logic                        dec_valid_o,
    output rv_exec_pkg::alu_op_t        alu_op_o,
    output rv_exec_pkg::word_t          alu_a_o,
    output rv_exec_pkg::word_t          alu_b_o,
    output rv_exec_pkg::word_t          rs1_val_o,
    output rv_exec_pkg::word_t          rs2_val_o,
    output rv_exec_pkg::word_t          imm_o,
    output rv_exec_pkg::word_t          pc_o,
    output rv_exec_pkg::reg_addr_t      rd_addr_o,
    output logic                        rd_we_o,
    output logic                        is_branch_o,
    output logic                        is_jump_o,
    output logic                        is_jalr_o,
    output rv_exec_pkg::br_funct_t      br_funct_o,
    output logic                        illegal_o
);

    rv_exec_pkg::opcode_t   opcode;
    logic [2:0]             funct3;
    logic                   funct7_b5;
    rv_exec_pkg::reg_addr_t rd;
    rv_exec_pkg::word_t     imm_itype;
    rv_exec_pkg::word_t     imm_btype;
    rv_exec_pkg::word_t     imm_utype;
    rv_exec_pkg::word_t     imm_jtype;
    logic                   is_reg_op;
    logic                   is_arith;
    logic                   writes_rd;
    logic                   take;
    rv_exec_pkg::alu_op_t   arith_op;
    rv_exec_pkg::alu_op_t   alu_op_d;
    rv_exec_pkg::word_t     alu_a_d;
    rv_exec_pkg::word_t     imm_d;

    // ==============================
    // fields and immediates
    // ==============================
    assign opcode    = instr_i[6:0];
    assign funct3    = instr_i[14:12];
    assign funct7_b5 = instr_i[30];
    assign rd        = instr_i[11:7];

    assign imm_itype = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_btype = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
    assign imm_utype = {instr_i[31:12], 12'b0};
    assign imm_jtype = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

    assign is_reg_op = (opcode == rv_exec_pkg::OPC_OP);
    assign is_arith  = is_reg_op || (opcode == rv_exec_pkg::OPC_OP_IMM);

    // funct3 to alu op, shared by both arithmetic forms
    always_comb begin
        case (funct3)
            3'b000:  arith_op = (is_reg_op && funct7_b5) ? rv_exec_pkg::ALU_SUB
                                                         : rv_exec_pkg::ALU_ADD;
            3'b001:  arith_op = rv_exec_pkg::ALU_SLL;
            3'b010:  arith_op = rv_exec_pkg::ALU_SLT;
            3'b011:  arith_op = rv_exec_pkg::ALU_SLTU;
            3'b100:  arith_op = rv_exec_pkg::ALU_XOR;
            3'b101:  arith_op = funct7_b5 ? rv_exec_pkg::ALU_SRA : rv_exec_pkg::ALU_SRL;
            3'b110:  arith_op = rv_exec_pkg::ALU_OR;
            default: arith_op = rv_exec_pkg::ALU_AND;
        endcase
    end

    // lui/auipc go through the adder too
    assign alu_op_d = is_arith ? arith_op : rv_exec_pkg::ALU_ADD;

    always_comb begin
        case (opcode)
            rv_exec_pkg::OPC_LUI,
            rv_exec_pkg::OPC_AUIPC:  imm_d = imm_utype;
            rv_exec_pkg::OPC_BRANCH: imm_d = imm_btype;
            rv_exec_pkg::OPC_JAL:    imm_d = imm_jtype;
            default:                 imm_d = imm_itype;
        endcase
    end

    always_comb begin
        case (opcode)
            rv_exec_pkg::OPC_AUIPC: alu_a_d = pc_i;
            rv_exec_pkg::OPC_LUI:   alu_a_d = '0;
            default:                alu_a_d = rs1_val_i;
        endcase
    end

    always_comb begin
        case (opcode)
            rv_exec_pkg::OPC_OP,
            rv_exec_pkg::OPC_OP_IMM,
            rv_exec_pkg::OPC_LUI,
            rv_exec_pkg::OPC_AUIPC,
            rv_exec_pkg::OPC_JAL,
            rv_exec_pkg::OPC_JALR:  writes_rd = 1'b1;
            default:                writes_rd = 1'b0; // branches and illegal
        endcase
    end

    // ==============================
    // pipeline register
    // ==============================
    assign in_ready_o = !dec_valid_o || dec_ready_i;
    assign take       = in_valid_i && in_ready_o;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid_o <= 1'b0;
        end else if (in_ready_o) begin
            dec_valid_o <= in_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            alu_op_o    <= alu_op_d;
            alu_a_o     <= alu_a_d;
            alu_b_o     <= is_reg_op ? rs2_val_i : imm_d;
            rs1_val_o   <= rs1_val_i;
            rs2_val_o   <= rs2_val_i;
            imm_o       <= imm_d;
            pc_o        <= pc_i;
            rd_addr_o   <= rd;
            rd_we_o     <= writes_rd && (rd != '0); // x0 stays zero
            is_branch_o <= (opcode == rv_exec_pkg::OPC_BRANCH);
            is_jump_o   <= (opcode == rv_exec_pkg::OPC_JAL) || (opcode == rv_exec_pkg::OPC_JALR);
            is_jalr_o   <= (opcode == rv_exec_pkg::OPC_JALR);
            br_funct_o  <= funct3;
            illegal_o   <= !writes_rd && (opcode != rv_exec_pkg::OPC_BRANCH);
        end
    end

    // a held write enable never points at x0
    assert property (@(posedge clk) disable iff (!rst_n)
        dec_valid_o |-> !(rd_we_o && (rd_addr_o == '0)));

endmodule

`default_nettype wire

/* verilog/exec_commit.sv */
`timescale 1ns/10ps
`default_nettype none

module exec_commit (
    input  wire                         clk,
    input  wire                         rst_n,
    // from the decode register and the two combinational units
    input  wire                         dec_valid_i,
    output logic                        dec_ready_o,
    input  wire rv_exec_pkg::word_t     alu_result_i,
    input  wire                         taken_i,
    input  wire rv_exec_pkg::word_t     target_i,
    input  wire rv_exec_pkg::word_t     link_i,
    input  wire                         is_jump_i,
    input  wire rv_exec_pkg::reg_addr_t rd_addr_i,
    input  wire                         rd_we_i,
    input  wire                         illegal_i,
    input  wire rv_exec_pkg::word_t     pc_i,
    // downstream handshake
    input  wire                         out_ready_i,
    output logic                        out_valid_o,
    output rv_exec_pkg::reg_addr_t      rd_addr_o,
    output logic                        rd_we_o,
    output rv_exec_pkg::word_t          result_o,
    output rv_exec_pkg::word_t          next_pc_o,
    output logic                        redirect_o,
    output logic                        illegal_o
);

    logic load;

    // free when empty or draining this cycle
    assign dec_ready_o = !out_valid_o || out_ready_i;
    assign load        = dec_valid_i && dec_ready_o;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid_o <= 1'b0;
        end else if (dec_ready_o) begin
            out_valid_o <= dec_valid_i;
        end
    end

    // ==============================
    // result register
    // ==============================
    always_ff @(posedge clk) begin
        if (load) begin
            rd_addr_o  <= rd_addr_i;
            rd_we_o    <= rd_we_i;
            result_o   <= is_jump_i ? link_i : alu_result_i; // jumps write the link
            next_pc_o  <= taken_i ? target_i : pc_i + rv_exec_pkg::INSTR_BYTES;
            redirect_o <= taken_i;
            illegal_o  <= illegal_i;
        end
    end

    // a stalled output keeps everything until the consumer takes it
    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid_o && !out_ready_i |=> out_valid_o
            && $stable(rd_addr_o) && $stable(rd_we_o) && $stable(result_o)
            && $stable(next_pc_o) && $stable(redirect_o) && $stable(illegal_o));

endmodule

`default_nettype wire

/* verilog/rv_exec_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_exec_unit (
    input  wire                         clk,
    input  wire                         rst_n,
    // upstream
    input  wire                         in_valid_i,
    output logic                        in_ready_o,
    input  wire rv_exec_pkg::word_t     instr_i,
    input  wire rv_exec_pkg::word_t     pc_i,
    input  wire rv_exec_pkg::word_t     rs1_val_i,
    input  wire rv_exec_pkg::word_t     rs2_val_i,
    // downstream
    output logic                        out_valid_o,
    input  wire                         out_ready_i,
    output rv_exec_pkg::reg_addr_t      rd_addr_o,
    output logic                        rd_we_o,
    output rv_exec_pkg::word_t          result_o,
    output rv_exec_pkg::word_t          next_pc_o,
    output logic                        redirect_o,
    output logic                        illegal_o
);

    // decoded bundle
    logic                   dec_valid;
    logic                   dec_ready;
    rv_exec_pkg::alu_op_t   alu_op;
    rv_exec_pkg::word_t     alu_a;
    rv_exec_pkg::word_t     alu_b;
    rv_exec_pkg::word_t     dec_rs1_val;
    rv_exec_pkg::word_t     dec_rs2_val;
    rv_exec_pkg::word_t     dec_imm;
    rv_exec_pkg::word_t     dec_pc;
    rv_exec_pkg::reg_addr_t dec_rd_addr;
    logic                   dec_rd_we;
    logic                   is_branch;
    logic                   is_jump;
    logic                   is_jalr;
    rv_exec_pkg::br_funct_t br_funct;
    logic                   dec_illegal;

    // execute results
    rv_exec_pkg::word_t     alu_result;
    logic                   br_taken;
    rv_exec_pkg::word_t     br_target;
    rv_exec_pkg::word_t     br_link;

    instr_decoder i_decoder (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .instr_i     (instr_i),
        .pc_i        (pc_i),
        .rs1_val_i   (rs1_val_i),
        .rs2_val_i   (rs2_val_i),
        .dec_ready_i (dec_ready),
        .dec_valid_o (dec_valid),
        .alu_op_o    (alu_op),
        .alu_a_o     (alu_a),
        .alu_b_o     (alu_b),
        .rs1_val_o   (dec_rs1_val),
        .rs2_val_o   (dec_rs2_val),
        .imm_o       (dec_imm),
        .pc_o        (dec_pc),
        .rd_addr_o   (dec_rd_addr),
        .rd_we_o     (dec_rd_we),
        .is_branch_o (is_branch),
        .is_jump_o   (is_jump),
        .is_jalr_o   (is_jalr),
        .br_funct_o  (br_funct),
        .illegal_o   (dec_illegal)
    );

    // alu and resolver run side by side
    alu i_alu (
        .alu_op_i (alu_op),
        .a_i      (alu_a),
        .b_i      (alu_b),
        .result_o (alu_result)
    );

    branch_resolver i_branch_resolver (
        .is_branch_i (is_branch),
        .is_jump_i   (is_jump),
        .is_jalr_i   (is_jalr),
        .br_funct_i  (br_funct),
        .rs1_val_i   (dec_rs1_val),
        .rs2_val_i   (dec_rs2_val),
        .imm_i       (dec_imm),
        .pc_i        (dec_pc),
        .taken_o     (br_taken),
        .target_o    (br_target),
        .link_o      (br_link)
    );

    exec_commit i_commit (
        .clk          (clk),
        .rst_n        (rst_n),
        .dec_valid_i  (dec_valid),
        .dec_ready_o  (dec_ready),
        .alu_result_i (alu_result),
        .taken_i      (br_taken),
        .target_i     (br_target),
        .link_i       (br_link),
        .is_jump_i    (is_jump),
        .rd_addr_i    (dec_rd_addr),
        .rd_we_i      (dec_rd_we),
        .illegal_i    (dec_illegal),
        .pc_i         (dec_pc),
        .out_ready_i  (out_ready_i),
        .out_valid_o  (out_valid_o),
        .rd_addr_o    (rd_addr_o),
        .rd_we_o      (rd_we_o),
        .result_o     (result_o),
        .next_pc_o    (next_pc_o),
        .redirect_o   (redirect_o),
        .illegal_o    (illegal_o)
    );

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
    parameter int HALF_PERIOD_NS = 4
) (
    output logic clk_o
);

    // free running, starts low
    initial begin
        clk_o = 1'b0;
        forever begin
            #(HALF_PERIOD_NS) clk_o = ~clk_o;
        end
    end

endmodule

`default_nettype wire

/* testbench/tb_rv_exec_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_rv_exec_unit;

    localparam int N_FIXED     = 500;  // out_ready held high
    localparam int N_RANDOM    = 1500; // random back-pressure
    localparam int WATCHDOG_NS = ((N_FIXED + N_RANDOM) * 20 + 16) * 8;

    typedef struct packed {
        logic [4:0]  rd_addr;
        logic        rd_we;
        logic [31:0] result;
        logic [31:0] next_pc;
        logic        redirect;
        logic        illegal;
        logic        writes;       // rd_addr and result are meaningful
        logic        timed;        // fixed two-edge latency expected
        int          accept_cycle;
    } expect_t;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    logic        in_ready;
    logic [31:0] instr;
    logic [31:0] pc;
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    logic        out_valid;
    logic        out_ready;
    logic [4:0]  rd_addr;
    logic        rd_we;
    logic [31:0] result;
    logic [31:0] next_pc;
    logic        redirect;
    logic        illegal;

    expect_t     exp_q[$];
    expect_t     new_item;
    expect_t     held;          // outputs seen at a stalled edge
    int          cycle;
    int          accepted;
    logic        took_last;
    logic        stalled;
    logic        fixed_latency;

    tb_clock_gen #(.HALF_PERIOD_NS(4)) i_clock_gen (.clk_o(clk));

    rv_exec_unit i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid_i  (in_valid),
        .in_ready_o  (in_ready),
        .instr_i     (instr),
        .pc_i        (pc),
        .rs1_val_i   (rs1_val),
        .rs2_val_i   (rs2_val),
        .out_valid_o (out_valid),
        .out_ready_i (out_ready),
        .rd_addr_o   (rd_addr),
        .rd_we_o     (rd_we),
        .result_o    (result),
        .next_pc_o   (next_pc),
        .redirect_o  (redirect),
        .illegal_o   (illegal)
    );

    // ==============================
    // reference model
    // ==============================
    function automatic logic lt_signed(input logic [31:0] a, input logic [31:0] b);
        return (a[31] != b[31]) ? a[31] : (a < b);
    endfunction

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        logic [31:0] fill;
        fill = {32{a[31]}} & ~(32'hffff_ffff >> b[4:0]); // sign bits shifted in
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'd0, lt_signed(a, b)};
            3'b011:  return {31'd0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return alt ? ((a >> b[4:0]) | fill) : (a >> b[4:0]);
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic expect_t predict(input logic [31:0] ins, input logic [31:0] pc_v,
                                        input logic [31:0] a, input logic [31:0] b);
        expect_t     e;
        logic [2:0]  f3;
        logic [31:0] imm_i;
        logic [31:0] imm_b;
        logic [31:0] imm_u;
        logic [31:0] imm_j;
        logic        cond;
        f3    = ins[14:12];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_u = {ins[31:12], 12'd0};
        imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        e         = '0;
        e.rd_addr = ins[11:7];
        e.next_pc = pc_v + 32'd4;
        case (ins[6:0])
            7'b0110011: begin // register-register
                e.writes = 1'b1;
                e.result = alu_ref(f3, ins[30] && (f3 == 3'b000 || f3 == 3'b101), a, b);
            end
            7'b0010011: begin // immediate, only srai uses bit 30
                e.writes = 1'b1;
                e.result = alu_ref(f3, ins[30] && (f3 == 3'b101), a, imm_i);
            end
            7'b0110111: begin
                e.writes = 1'b1;
                e.result = imm_u;
            end
            7'b0010111: begin
                e.writes = 1'b1;
                e.result = pc_v + imm_u;
            end
            7'b1101111, 7'b1100111: begin // jal, jalr
                e.writes   = 1'b1;
                e.result   = pc_v + 32'd4;
                e.redirect = 1'b1;
                e.next_pc  = ins[3] ? pc_v + imm_j : (a + imm_i) & 32'hffff_fffe;
            end
            7'b1100011: begin
                case (f3)
                    3'b000:  cond = (a == b);
                    3'b001:  cond = (a != b);
                    3'b100:  cond = lt_signed(a, b);
                    3'b101:  cond = !lt_signed(a, b);
                    3'b110:  cond = (a < b);
                    default: cond = !(a < b);
                endcase
                if (cond) begin
                    e.redirect = 1'b1;
                    e.next_pc  = pc_v + imm_b;
                end
            end
            default: e.illegal = 1'b1;
        endcase
        e.rd_we = e.writes && (e.rd_addr != 5'd0);
        return e;
    endfunction

    // ==============================
    // stimulus
    // ==============================
    function automatic logic [31:0] pick_operand();
        logic [31:0] r;
        r = $urandom;
        case (r[2:0])
            3'd0:    return 32'h0000_0000;
            3'd1:    return 32'h8000_0000; // most negative
            3'd2:    return 32'hffff_ffff;
            3'd3:    return {27'd0, r[8:4]};
            default: return $urandom;
        endcase
    endfunction

    task automatic make_item();
        logic [31:0] r;
        logic [31:0] ins;
        logic [2:0]  f3;
        int          kind;
        ins  = $urandom;
        r    = $urandom;
        kind = $urandom % 16;
        f3   = ins[14:12];
        if (r[2:0] == 3'd0) begin
            ins[11:7] = 5'd0;
        end
        case (kind)
            0, 1, 2, 3: begin
                ins[6:0]   = 7'b0110011;
                ins[31:25] = (r[3] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'b0100000 : 7'd0;
            end
            4, 5, 6, 7: begin
                ins[6:0] = 7'b0010011;
                if (f3 == 3'b001 || f3 == 3'b101) begin // shift immediates
                    ins[31:25] = (r[3] && f3 == 3'b101) ? 7'b0100000 : 7'd0;
                end
            end
            8:  ins[6:0] = 7'b0110111;
            9:  ins[6:0] = 7'b0010111;
            10, 11: begin
                ins[6:0] = 7'b1100011;
                if (f3[2:1] == 2'b01) begin
                    ins[13] = 1'b0; // 010 and 011 are no branch
                end
            end
            12: ins[6:0] = 7'b1101111;
            13: begin
                ins[6:0]   = 7'b1100111;
                ins[14:12] = 3'b000;
            end
            14: ins[6:0] = r[4] ? 7'b0000011 : 7'b0100011; // load or store
            default: begin
                ins[6:0] = r[10:4];
                while (ins[6:0] inside {7'b0110011, 7'b0010011, 7'b0110111, 7'b0010111,
                                        7'b1101111, 7'b1100111, 7'b1100011}) begin
                    ins[6:0] = ins[6:0] + 7'd1;
                end
            end
        endcase
        instr   = ins;
        pc      = {r[31:2], 2'b00};
        rs1_val = pick_operand();
        rs2_val = (r[1:0] == 2'b00) ? rs1_val : pick_operand(); // equal operands now and then
    endtask

    task automatic send_items(input int count, input logic random_ready);
        int   offered;
        logic done;
        offered = 0;
        done    = 1'b0;
        while (!done) begin
            @(negedge clk);
            out_ready = random_ready ? (($urandom % 3) != 0) : 1'b1;
            if (!in_valid || took_last) begin
                if (offered == count) begin
                    in_valid = 1'b0;
                    done     = 1'b1;
                end else if (($urandom % 4) != 0) begin
                    make_item();
                    in_valid = 1'b1;
                    offered  = offered + 1;
                end else begin
                    in_valid = 1'b0;
                end
            end
        end
    endtask

    task automatic drain(input logic random_ready);
        while (exp_q.size() != 0) begin
            @(negedge clk);
            out_ready = random_ready ? (($urandom % 3) != 0) : 1'b1;
        end
    endtask

    // ==============================
    // checking
    // ==============================
    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_equal(input logic [31:0] got, input logic [31:0] want,
                               input string what);
        if (got !== want) begin
            stop_on_error($sformatf("Mismatch at %0t ns: %s is %h, expected %h",
                                    $time, what, got, want));
        end
    endtask

    task automatic check_output();
        expect_t e;
        if (exp_q.size() == 0) begin
            stop_on_error($sformatf("Output handshake at %0t ns with no item in flight", $time));
        end else begin
            e = exp_q.pop_front();
            check_equal({31'd0, illegal}, {31'd0, e.illegal}, "illegal_o");
            check_equal({31'd0, rd_we}, {31'd0, e.rd_we}, "rd_we_o");
            check_equal({31'd0, redirect}, {31'd0, e.redirect}, "redirect_o");
            check_equal(next_pc, e.next_pc, "next_pc_o");
            if (e.writes) begin
                check_equal({27'd0, rd_addr}, {27'd0, e.rd_addr}, "rd_addr_o");
                check_equal(result, e.result, "result_o");
            end
            if (e.timed) begin
                check_equal(cycle, e.accept_cycle + 2, "edge of output handshake");
            end
        end
    endtask

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (rst_n) begin // two stages, so ready drops only when both hold an item
            check_equal({31'd0, in_ready}, {31'd0, (exp_q.size() < 2) || out_ready},
                        "in_ready_o");
        end
        took_last = in_valid && in_ready;
        if (took_last) begin
            new_item              = predict(instr, pc, rs1_val, rs2_val);
            new_item.timed        = fixed_latency;
            new_item.accept_cycle = cycle;
            exp_q.push_back(new_item);
            accepted = accepted + 1;
        end
        if (stalled) begin // previous edge was a stall
            check_equal({31'd0, out_valid}, 32'd1, "out_valid_o while stalled");
            check_equal(result, held.result, "result_o while stalled");
            check_equal(next_pc, held.next_pc, "next_pc_o while stalled");
            check_equal({24'd0, rd_addr, rd_we, redirect, illegal},
                        {24'd0, held.rd_addr, held.rd_we, held.redirect, held.illegal},
                        "control outputs while stalled");
        end
        if (out_valid && out_ready) begin
            check_output();
        end
        stalled       = out_valid && !out_ready;
        held.rd_addr  = rd_addr;
        held.rd_we    = rd_we;
        held.result   = result;
        held.next_pc  = next_pc;
        held.redirect = redirect;
        held.illegal  = illegal;
    end

    initial begin
        #(WATCHDOG_NS);
        stop_on_error($sformatf("Timeout after %0d ns, the run did not finish", WATCHDOG_NS));
    end

    initial begin
        void'($urandom(29));
        rst_n         = 1'b0;
        in_valid      = 1'b0;
        instr         = '0;
        pc            = '0;
        rs1_val       = '0;
        rs2_val       = '0;
        out_ready     = 1'b0;
        fixed_latency = 1'b1;
        cycle         = 0;
        accepted      = 0;
        took_last     = 1'b0;
        stalled       = 1'b0;
        held          = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        send_items(N_FIXED, 1'b0); // full throughput, latency checked
        drain(1'b0);
        fixed_latency = 1'b0;
        send_items(N_RANDOM, 1'b1);
        drain(1'b1);
        out_ready = 1'b1;
        repeat (4) @(negedge clk); // nothing more may come out

        check_equal(accepted, N_FIXED + N_RANDOM, "number of accepted items");
        if (exp_q.size() == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            stop_on_error($sformatf("%0d items never came out", exp_q.size()));
        end
    end

endmodule

`default_nettype wire

/* flist.f */
verilog/rv_exec_pkg.sv
verilog/alu.sv
verilog/branch_resolver.sv
verilog/instr_decoder.sv
verilog/exec_commit.sv
verilog/rv_exec_unit.sv
testbench/tb_clock_gen.sv
testbench/tb_rv_exec_unit.sv

/* Makefile */
# Verilator flow for the RV32I execute unit

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --top-module rv_exec_unit \
		verilog/rv_exec_pkg.sv verilog/alu.sv verilog/branch_resolver.sv \
		verilog/instr_decoder.sv verilog/exec_commit.sv verilog/rv_exec_unit.sv
	verilator --lint-only --timing --top-module tb_rv_exec_unit -f flist.f

# $fatal in the testbench makes the binary exit with a failing status
sim:
	verilator --binary --timing --assert --top-module tb_rv_exec_unit \
		-f flist.f -o tb_rv_exec_unit
	./obj_dir/tb_rv_exec_unit

clean:
	rm -rf obj_dir
